/* Bender.yml */
package:
  name: ssb_index_detector

sources:
  - pbch_pkg.sv
  - dmrs_wr_if.sv
  - dmrs_rd_if.sv
  - dmrs_generator.sv
  - dmrs_table.sv
  - ibar_detector.sv
  - ssb_index_detector.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_ssb_index_detector.sv

/* build.f */
+incdir+.
pbch_pkg.sv
dmrs_wr_if.sv
dmrs_rd_if.sv
dmrs_generator.sv
dmrs_table.sv
ibar_detector.sv
ssb_index_detector.sv
tb_ssb_index_detector.sv

/* dmrs_generator.sv */
`timescale 1ns/1ps

module dmrs_generator (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  logic [pbch_pkg::N_ID_W-1:0]   n_id_i,
    input  logic                          n_id_valid_i,
    dmrs_wr_if.gen                        wr
);

    pbch_pkg::gen_state_e                 state;
    logic [pbch_pkg::N_ID_W-1:0]          n_id_q;
    logic [pbch_pkg::STEP_W-1:0]          step_cnt;
    logic [pbch_pkg::LFSR_N-1:0]          x1;
    logic [pbch_pkg::LFSR_N-1:0]          x2 [pbch_pkg::NUM_IBAR];
    logic [pbch_pkg::NUM_IBAR-1:0]        gold;
    logic [pbch_pkg::NUM_IBAR-1:0]        even_q;

    // c_init = 2048*(ibar+1)*(N_id/4+1) + 64*(ibar+1) + N_id mod 4
    function automatic logic [pbch_pkg::LFSR_N-1:0] c_init_f(
        input int unsigned                 ibar,
        input logic [pbch_pkg::N_ID_W-1:0] n_id
    );
        logic [31:0] ibar_p1;
        logic [31:0] grp_p1;
        logic [31:0] sum;
        ibar_p1 = 32'(ibar) + 32'd1;
        grp_p1  = 32'(n_id >> 2) + 32'd1;
        sum     = ((ibar_p1 * grp_p1) << 11) + (ibar_p1 << 6) + 32'(n_id[1:0]);
        return sum[pbch_pkg::LFSR_N-1:0];
    endfunction

    // bit 0 of each register is the oldest sequence element
    always_comb begin
        for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
            gold[i] = x1[0] ^ x2[i][0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state    <= pbch_pkg::GEN_IDLE;
            step_cnt <= '0;
            wr.clear <= 1'b0;
            wr.wr_en <= 1'b0;
        end else begin
            wr.clear <= 1'b0;
            wr.wr_en <= 1'b0;
            // a new cell ID restarts generation from any state
            if (n_id_valid_i) begin
                state    <= pbch_pkg::GEN_LOAD;
                wr.clear <= 1'b1;
            end else begin
                case (state)
                    pbch_pkg::GEN_LOAD: begin
                        step_cnt <= '0;
                        state    <= pbch_pkg::GEN_SKIP;
                    end
                    pbch_pkg::GEN_SKIP: begin
                        if (step_cnt == pbch_pkg::SKIP_LAST) begin
                            step_cnt <= '0;
                            state    <= pbch_pkg::GEN_STORE;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                    pbch_pkg::GEN_STORE: begin
                        // every odd output completes one pilot word
                        wr.wr_en <= step_cnt[0];
                        if (step_cnt == pbch_pkg::STORE_LAST) begin
                            state <= pbch_pkg::GEN_DONE;
                        end
                        step_cnt <= step_cnt + 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (n_id_valid_i) begin
            n_id_q    <= n_id_i;
            wr.offset <= n_id_i[1:0];
        end
        if (state == pbch_pkg::GEN_LOAD) begin
            x1 <= {{(pbch_pkg::LFSR_N - 1){1'b0}}, 1'b1};
            for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
                x2[i] <= c_init_f(i, n_id_q);
            end
        end else if (state == pbch_pkg::GEN_SKIP || state == pbch_pkg::GEN_STORE) begin
            // x1 taps 3 and 0, x2 taps 3, 2, 1 and 0
            x1 <= {x1[3] ^ x1[0], x1[pbch_pkg::LFSR_N-1:1]};
            for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
                x2[i] <= {x2[i][3] ^ x2[i][2] ^ x2[i][1] ^ x2[i][0],
                          x2[i][pbch_pkg::LFSR_N-1:1]};
            end
        end
        if (state == pbch_pkg::GEN_STORE) begin
            if (!step_cnt[0]) begin
                even_q <= gold;
            end else begin
                wr.wr_addr <= step_cnt[pbch_pkg::PILOT_ADDR_W:1];
                for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
                    wr.wr_data[i] <= {even_q[i], gold[i]};
                end
            end
        end
    end

endmodule

/* dmrs_rd_if.sv */
`timescale 1ns/1ps

interface dmrs_rd_if;

    logic [pbch_pkg::PILOT_ADDR_W-1:0]   rd_addr;
    pbch_pkg::dmrs_word_t                rd_data;
    // ready is a level that stays high while the stored sequences are complete
    logic                                ready;
    logic [1:0]                          offset;

    modport tbl (
        input  rd_addr,
        output rd_data, ready, offset
    );

    modport det (
        output rd_addr,
        input  rd_data, ready, offset
    );

endinterface

/* dmrs_table.sv */
`timescale 1ns/1ps

module dmrs_table (
    input  logic      clk_i,
    input  logic      reset_ni,
    dmrs_wr_if.tbl    wr,
    dmrs_rd_if.tbl    rd
);

    pbch_pkg::dmrs_word_t mem [pbch_pkg::PILOTS_PER_SYM];
    logic                 last_wr_q;

    always_ff @(posedge clk_i) begin
        if (wr.wr_en) begin
            mem[wr.wr_addr] <= wr.wr_data;
        end
    end

    // the detector reads one pilot word per cycle without latency
    assign rd.rd_data = mem[rd.rd_addr];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd.ready  <= 1'b0;
            rd.offset <= 2'd0;
            last_wr_q <= 1'b0;
        end else begin
            last_wr_q <= wr.wr_en && (wr.wr_addr == pbch_pkg::LAST_PILOT);
            if (wr.clear) begin
                // offset changes together with the sequences it belongs to
                rd.ready  <= 1'b0;
                rd.offset <= wr.offset;
                last_wr_q <= 1'b0;
            end else if (last_wr_q) begin
                rd.ready <= 1'b1;
            end
        end
    end

endmodule

/* dmrs_wr_if.sv */
`timescale 1ns/1ps

interface dmrs_wr_if;

    // a new cell ID invalidates the table and sets its pilot offset
    logic                                clear;
    logic [1:0]                          offset;
    logic                                wr_en;
    logic [pbch_pkg::PILOT_ADDR_W-1:0]   wr_addr;
    pbch_pkg::dmrs_word_t                wr_data;

    modport gen (
        output clear, offset, wr_en, wr_addr, wr_data
    );

    modport tbl (
        input  clear, offset, wr_en, wr_addr, wr_data
    );

endinterface

/* ibar_detector.sv */
`timescale 1ns/1ps

module ibar_detector (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  logic [pbch_pkg::IQ_W-1:0]     iq_data_i,
    input  logic                          iq_valid_i,
    input  logic                          pbch_start_i,
    dmrs_rd_if.det                        rd,
    output logic [pbch_pkg::IBAR_W-1:0]   ibar_o,
    output logic                          ibar_valid_o
);

    pbch_pkg::det_state_e                 state;
    logic [pbch_pkg::SC_CNT_W-1:0]        sc_cnt;
    logic [pbch_pkg::PILOT_ADDR_W-1:0]    pilot_addr;
    logic [pbch_pkg::IQ_W-1:0]            iq_q;
    logic [pbch_pkg::SC_W-1:0]            sc_q;
    logic                                 start_ok;
    logic                                 take;
    logic                                 take_q;
    logic                                 is_pilot;
    pbch_pkg::qpsk_t                      hard;
    logic [1:0]                           match [pbch_pkg::NUM_IBAR];
    logic [pbch_pkg::CORR_W-1:0]          corr [pbch_pkg::NUM_IBAR];
    logic [pbch_pkg::IBAR_W-1:0]          best_idx;
    logic [pbch_pkg::CORR_W-1:0]          best_corr;

    assign start_ok = (state == pbch_pkg::DET_IDLE) && pbch_start_i && rd.ready;
    // the start cycle already counts as part of the symbol
    assign take = iq_valid_i && (start_ok ||
                  (state == pbch_pkg::DET_COLLECT && sc_cnt != pbch_pkg::SC_END));

    // hard decision is the sign of the real part and the sign of the imaginary part
    assign hard        = {iq_q[pbch_pkg::IQ_W/2-1], iq_q[pbch_pkg::IQ_W-1]};
    assign is_pilot    = take_q && (sc_q[1:0] == rd.offset);
    assign rd.rd_addr  = pilot_addr;

    always_comb begin
        for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
            match[i] = {1'b0, rd.rd_data[i][1] == hard[1]} +
                       {1'b0, rd.rd_data[i][0] == hard[0]};
        end
    end

    // strict compare from zero keeps the lowest index on ties
    always_comb begin
        best_idx  = '0;
        best_corr = '0;
        for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
            if (corr[i] > best_corr) begin
                best_corr = corr[i];
                best_idx  = i[pbch_pkg::IBAR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            iq_q <= iq_data_i;
            sc_q <= start_ok ? '0 : sc_cnt[pbch_pkg::SC_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state        <= pbch_pkg::DET_IDLE;
            sc_cnt       <= '0;
            pilot_addr   <= '0;
            take_q       <= 1'b0;
            ibar_o       <= '0;
            ibar_valid_o <= 1'b0;
            for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
                corr[i] <= '0;
            end
        end else begin
            take_q       <= take;
            ibar_valid_o <= 1'b0;
            if (is_pilot) begin
                pilot_addr <= pilot_addr + 1'b1;
                for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
                    corr[i] <= corr[i] + {{(pbch_pkg::CORR_W - 2){1'b0}}, match[i]};
                end
            end
            case (state)
                pbch_pkg::DET_IDLE: begin
                    if (start_ok) begin
                        sc_cnt <= {{pbch_pkg::SC_W{1'b0}}, iq_valid_i};
                        state  <= pbch_pkg::DET_COLLECT;
                    end
                end
                pbch_pkg::DET_COLLECT: begin
                    // one extra cycle lets the last sample reach the counters
                    if (sc_cnt == pbch_pkg::SC_END) begin
                        state <= pbch_pkg::DET_DECIDE;
                    end else if (iq_valid_i) begin
                        sc_cnt <= sc_cnt + 1'b1;
                    end
                end
                pbch_pkg::DET_DECIDE: begin
                    ibar_o       <= best_idx;
                    ibar_valid_o <= 1'b1;
                    pilot_addr   <= '0;
                    for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
                        corr[i] <= '0;
                    end
                    state <= pbch_pkg::DET_IDLE;
                end
                default: state <= pbch_pkg::DET_IDLE;
            endcase
        end
    end

endmodule

/* pbch_pkg.sv */
package pbch_pkg;

    // one IQ sample holds the real part in the low half and the imaginary part in the high half
    localparam int IQ_W           = 32;
    localparam int N_ID_W         = 10;
    localparam int NUM_IBAR       = 8;
    localparam int IBAR_W         = 3;
    localparam int FFT_LEN        = 256;
    localparam int SC_W           = 8;
    localparam int SC_CNT_W       = SC_W + 1;
    localparam int PILOTS_PER_SYM = 64;
    localparam int PILOT_ADDR_W   = 6;
    localparam int GOLD_NC        = 1600;
    localparam int LFSR_N         = 31;
    localparam int STEP_W         = 11;

    // up to 64 pilots with two bits each, so the count never exceeds 128
    localparam int CORR_W         = 8;

    localparam logic [STEP_W-1:0]       SKIP_LAST  = STEP_W'(GOLD_NC - 1);
    localparam logic [STEP_W-1:0]       STORE_LAST = STEP_W'(2 * PILOTS_PER_SYM - 1);
    localparam logic [PILOT_ADDR_W-1:0] LAST_PILOT = PILOT_ADDR_W'(PILOTS_PER_SYM - 1);
    localparam logic [SC_CNT_W-1:0]     SC_END     = SC_CNT_W'(FFT_LEN);

    // bit 1 comes from the even Gold output, bit 0 from the odd one
    typedef logic [1:0] qpsk_t;

    // one pilot of every candidate sequence, indexed by ibar
    typedef qpsk_t [NUM_IBAR-1:0] dmrs_word_t;

    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_LOAD,
        GEN_SKIP,
        GEN_STORE,
        GEN_DONE
    } gen_state_e;

    typedef enum logic [1:0] {
        DET_IDLE,
        DET_COLLECT,
        DET_DECIDE
    } det_state_e;

endpackage

/* ssb_index_detector.sv */
`timescale 1ns/1ps

module ssb_index_detector (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  logic [pbch_pkg::IQ_W-1:0]     iq_data_i,
    input  logic                          iq_valid_i,
    input  logic [pbch_pkg::N_ID_W-1:0]   n_id_i,
    input  logic                          n_id_valid_i,
    input  logic                          pbch_start_i,
    output logic                          dmrs_ready_o,
    output logic [pbch_pkg::IBAR_W-1:0]   ibar_o,
    output logic                          ibar_valid_o
);

    dmrs_wr_if wr_if ();
    dmrs_rd_if rd_if ();

    // the generator fills the table once per cell ID
    dmrs_generator dmrs_generator_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .n_id_i       (n_id_i),
        .n_id_valid_i (n_id_valid_i),
        .wr           (wr_if.gen)
    );

    dmrs_table dmrs_table_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .wr       (wr_if.tbl),
        .rd       (rd_if.tbl)
    );

    ibar_detector ibar_detector_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .iq_data_i    (iq_data_i),
        .iq_valid_i   (iq_valid_i),
        .pbch_start_i (pbch_start_i),
        .rd           (rd_if.det),
        .ibar_o       (ibar_o),
        .ibar_valid_o (ibar_valid_o)
    );

    assign dmrs_ready_o = rd_if.ready;

endmodule

/* tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// xorshift32 state with a fixed seed so every run sees the same stimulus
logic [31:0] rng_state = 32'd63290;

function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic logic [31:0] c_init_of(input int ibar, input int n_id);
    return 2048 * (ibar + 1) * (n_id / 4 + 1) + 64 * (ibar + 1) + n_id % 4;
endfunction

// Gold sequence written as the two recurrences with c(0) in bit 0
function automatic logic [2*pbch_pkg::PILOTS_PER_SYM-1:0] gold_sequence(
    input logic [31:0] c_init
);
    bit x1 [pbch_pkg::GOLD_NC + 2 * pbch_pkg::PILOTS_PER_SYM + pbch_pkg::LFSR_N];
    bit x2 [pbch_pkg::GOLD_NC + 2 * pbch_pkg::PILOTS_PER_SYM + pbch_pkg::LFSR_N];
    logic [2*pbch_pkg::PILOTS_PER_SYM-1:0] c;
    for (int n = 0; n < pbch_pkg::LFSR_N; n++) begin
        x1[n] = (n == 0);
        x2[n] = c_init[n];
    end
    for (int n = 0; n < pbch_pkg::GOLD_NC + 2 * pbch_pkg::PILOTS_PER_SYM; n++) begin
        x1[n + 31] = x1[n + 3] ^ x1[n];
        x2[n + 31] = x2[n + 3] ^ x2[n + 2] ^ x2[n + 1] ^ x2[n];
    end
    for (int n = 0; n < 2 * pbch_pkg::PILOTS_PER_SYM; n++) begin
        c[n] = x1[n + pbch_pkg::GOLD_NC] ^ x2[n + pbch_pkg::GOLD_NC];
    end
    return c;
endfunction

`endif

/* tb_ssb_index_detector.sv */
`timescale 1ns/1ps

module tb_ssb_index_detector;

    localparam int NUM_LOADS       = 7;
    localparam int NUM_SYMBOLS     = 14;
    localparam int WATCHDOG_CYCLES = NUM_LOADS * 2000 + NUM_SYMBOLS * 700;
    // load cycle, discarded outputs, two outputs per pilot and two register stages
    localparam int READY_CYCLES    = 1 + pbch_pkg::GOLD_NC + 2 * pbch_pkg::PILOTS_PER_SYM + 2;
    localparam int RESULT_CYCLES   = 2;

    logic                          clk_i;
    logic                          reset_ni;
    logic [pbch_pkg::IQ_W-1:0]     iq_data_i;
    logic                          iq_valid_i;
    logic [pbch_pkg::N_ID_W-1:0]   n_id_i;
    logic                          n_id_valid_i;
    logic                          pbch_start_i;
    logic                          dmrs_ready_o;
    logic [pbch_pkg::IBAR_W-1:0]   ibar_o;
    logic                          ibar_valid_o;

    int    errors       = 0;
    int    checks       = 0;
    int    valid_pulses = 0;
    string test_name    = "reset";

    `include "tb_ref_model.svh"

    ssb_index_detector ssb_index_detector_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .iq_data_i    (iq_data_i),
        .iq_valid_i   (iq_valid_i),
        .n_id_i       (n_id_i),
        .n_id_valid_i (n_id_valid_i),
        .pbch_start_i (pbch_start_i),
        .dmrs_ready_o (dmrs_ready_o),
        .ibar_o       (ibar_o),
        .ibar_valid_o (ibar_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (reset_ni && ibar_valid_o) begin
            valid_pulses++;
        end
    end

    single_pulse_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
            ibar_valid_o |=> !ibar_valid_o)
        else begin
            errors++;
            $display("Error in %s: ibar_valid_o stayed high for more than one cycle", test_name);
        end

    // the result register only moves together with its strobe
    ibar_hold_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
            !ibar_valid_o |-> $stable(ibar_o))
        else begin
            errors++;
            $display("Error in %s: ibar_o changed without ibar_valid_o", test_name);
        end

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("Mismatch in %s, %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string text);
        errors++;
        $display("Error in %s: %s", test_name, text);
    endtask

    task automatic pulse_n_id(input int n_id);
        @(posedge clk_i);
        #2;
        n_id_i       = n_id[pbch_pkg::N_ID_W-1:0];
        n_id_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        n_id_valid_i = 1'b0;
    endtask

    task automatic load_and_check(input int n_id);
        int cycles;
        cycles = 0;
        pulse_n_id(n_id);
        do begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (cycles == 1) begin
                check_value("dmrs_ready_o after load", 0, dmrs_ready_o);
            end
        end while (!dmrs_ready_o && cycles < 2 * READY_CYCLES);
        if (!dmrs_ready_o) begin
            report_failure("dmrs_ready_o never rose after the cell ID was loaded");
        end else begin
            check_value("dmrs_ready_o latency", READY_CYCLES, cycles);
        end
    endtask

    task automatic send_symbol(input int n_id, input int ibar, input bit gaps);
        logic [2*pbch_pkg::PILOTS_PER_SYM-1:0] seq;
        logic [pbch_pkg::IQ_W-1:0]             sample;
        int                                    m;
        int                                    cycles;
        int                                    pulses_before;
        bit                                    first;
        seq           = gold_sequence(c_init_of(ibar, n_id));
        pulses_before = valid_pulses;
        first         = 1'b1;
        @(posedge clk_i);
        #2;
        for (int k = 0; k < pbch_pkg::FFT_LEN; k++) begin
            if (gaps && next_random() % 2 == 1) begin
                iq_valid_i   = 1'b0;
                pbch_start_i = first;
                first        = 1'b0;
                @(posedge clk_i);
                #2;
            end
            sample = next_random();
            if (k % 4 == n_id % 4) begin
                m = k / 4;
                // sign of the real part carries c(2m), sign of the imaginary part c(2m+1)
                sample[pbch_pkg::IQ_W/2-1] = seq[2*m];
                sample[pbch_pkg::IQ_W-1]   = seq[2*m+1];
            end
            iq_data_i    = sample;
            iq_valid_i   = 1'b1;
            pbch_start_i = first;
            first        = 1'b0;
            @(posedge clk_i);
            #2;
        end
        iq_valid_i   = 1'b0;
        pbch_start_i = 1'b0;
        cycles       = 0;
        while (!ibar_valid_o && cycles < 20) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (!ibar_valid_o) begin
            report_failure("no ibar_valid_o within 20 cycles after the last sample");
        end else begin
            check_value("ibar_valid_o latency", RESULT_CYCLES, cycles);
            check_value("ibar_o", ibar, ibar_o);
        end
        repeat (4) @(posedge clk_i);
        #1;
        check_value("ibar_valid_o pulses", 1, valid_pulses - pulses_before);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int cells [4];
        int cell_a;
        int cell_b;
        int ibar;
        reset_ni     = 1'b0;
        iq_data_i    = '0;
        iq_valid_i   = 1'b0;
        n_id_i       = '0;
        n_id_valid_i = 1'b0;
        pbch_start_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;

        check_value("dmrs_ready_o", 0, dmrs_ready_o);
        check_value("ibar_valid_o", 0, ibar_valid_o);
        check_value("ibar_o", 0, ibar_o);
        // a start without a stored sequence must be ignored
        @(posedge clk_i);
        #2;
        pbch_start_i = 1'b1;
        iq_valid_i   = 1'b1;
        repeat (pbch_pkg::FFT_LEN) begin
            iq_data_i = next_random();
            @(posedge clk_i);
            #2;
            pbch_start_i = 1'b0;
        end
        iq_valid_i = 1'b0;
        repeat (600 - pbch_pkg::FFT_LEN) @(posedge clk_i);
        #1;
        check_value("ibar_valid_o pulses before ready", 0, valid_pulses);

        test_name = "ready_timing";
        cell_a = next_random() % 1008;
        load_and_check(cell_a);

        test_name = "all_ibar";
        for (int i = 0; i < pbch_pkg::NUM_IBAR; i++) begin
            send_symbol(cell_a, i, 1'b0);
        end

        test_name = "cell_offsets";
        cells[0] = 0;
        cells[1] = 1007;
        cells[2] = (next_random() % 252) * 4 + 1;
        cells[3] = (next_random() % 252) * 4 + 2;
        foreach (cells[i]) begin
            ibar = next_random() % pbch_pkg::NUM_IBAR;
            load_and_check(cells[i]);
            send_symbol(cells[i], ibar, 1'b1);
        end

        test_name = "reload";
        cell_a = (next_random() % 252) * 4 + 2;
        pulse_n_id(cell_a);
        @(posedge clk_i);
        #1;
        check_value("dmrs_ready_o after load", 0, dmrs_ready_o);
        // restart while the first load is still skipping outputs
        repeat (800) @(posedge clk_i);
        #1;
        check_value("dmrs_ready_o during generation", 0, dmrs_ready_o);
        cell_b = (next_random() % 252) * 4 + 1;
        load_and_check(cell_b);
        ibar = next_random() % pbch_pkg::NUM_IBAR;
        send_symbol(cell_b, ibar, 1'b1);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
